//--- common/axi_ic_pkg.sv
package axi_ic_pkg;

  localparam int ADDR_W     = 40;
  localparam int ID_W       = 8;
  localparam int DATA_W     = 128;
  localparam int RESP_W     = 2;
  localparam int NUM_SLAVES = 4;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [ID_W-1:0]   id_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [RESP_W-1:0] resp_t;

  typedef data_t [NUM_SLAVES-1:0] slv_data_t;
  typedef id_t   [NUM_SLAVES-1:0] slv_id_t;
  typedef resp_t [NUM_SLAVES-1:0] slv_resp_t;

  // Inclusive region bounds
  localparam addr_t SRAM_START = 40'h00_0000_0000;
  localparam addr_t SRAM_END   = 40'h00_01ff_ffff;
  localparam addr_t ERR1_START = 40'h00_0200_0000;
  localparam addr_t ERR1_END   = 40'h00_0fff_ffff;
  localparam addr_t APB_START  = 40'h00_1000_0000;
  localparam addr_t APB_END    = 40'h00_1fff_ffff;
  localparam addr_t ERR2_START = 40'h00_2000_0000;
  localparam addr_t ERR2_END   = 40'hff_ffff_ffff;

  // Value equals the slave port index
  typedef enum logic [1:0] {
    REGION_SRAM = 2'd0,
    REGION_ERR1 = 2'd1,
    REGION_APB  = 2'd2,
    REGION_ERR2 = 2'd3
  } region_e;

  function automatic region_e decode_region(addr_t addr);
    region_e region;
    if (addr inside {[SRAM_START:SRAM_END]}) begin
      region = REGION_SRAM;
    end else if (addr inside {[ERR1_START:ERR1_END]}) begin
      region = REGION_ERR1;
    end else if (addr inside {[APB_START:APB_END]}) begin
      region = REGION_APB;
    end else if (addr inside {[ERR2_START:ERR2_END]}) begin
      region = REGION_ERR2;
    end else begin
      region = REGION_ERR2; // Map covers the whole space
    end
    return region;
  endfunction

endpackage

//--- write_path/write_addr_table.sv
`timescale 1ns/1ps

module write_addr_table (
  input  logic                                aclk,
  input  logic                                aresetn,
  input  axi_ic_pkg::addr_t                   awaddr,
  input  axi_ic_pkg::id_t                     awid,
  input  logic                                awvalid,
  input  logic [axi_ic_pkg::NUM_SLAVES-1:0]   awready_s,
  input  axi_ic_pkg::id_t                     wid,
  input  logic                                wvalid,
  input  logic                                wlast,
  input  logic [axi_ic_pkg::NUM_SLAVES-1:0]   wready_s,
  output logic                                awready,
  output logic [axi_ic_pkg::NUM_SLAVES-1:0]   awvalid_s,
  output logic                                wready,
  output logic [axi_ic_pkg::NUM_SLAVES-1:0]   wvalid_s
);

  import axi_ic_pkg::*;

  region_e                 aw_region;
  logic                    aw_busy;
  logic                    aw_fire;
  logic                    w_hit;
  logic [1:0]              w_idx;
  region_e                 w_region;
  logic                    w_done;

  logic [NUM_SLAVES-1:0]   ent_valid;
  id_t                     ent_id   [NUM_SLAVES];
  addr_t                   ent_addr [NUM_SLAVES];

  assign aw_region = decode_region(awaddr);
  assign aw_busy   = ent_valid[aw_region]; // Burst still open in region
  assign aw_fire   = awvalid && awready;

  always_comb begin
    awvalid_s            = '0;
    awvalid_s[aw_region] = awvalid && !aw_busy;
    awready              = awready_s[aw_region] && !aw_busy;
  end

  // Lowest matching entry wins
  always_comb begin
    w_hit = 1'b0;
    w_idx = '0;
    for (int i = NUM_SLAVES - 1; i >= 0; i--) begin
      if (ent_valid[i] && (ent_id[i] == wid)) begin
        w_hit = 1'b1;
        w_idx = 2'(i);
      end
    end
  end

  assign w_region = decode_region(ent_addr[w_idx]); // Stored address picks the slave

  always_comb begin
    wvalid_s           = '0;
    wvalid_s[w_region] = wvalid && w_hit;
    wready             = w_hit && wready_s[w_region];
  end

  assign w_done = wvalid && wready && wlast;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      ent_valid <= '0;
    end else begin
      if (aw_fire) begin
        ent_valid[aw_region] <= 1'b1;
      end
      if (w_done) begin
        ent_valid[w_region] <= 1'b0; // Burst finished
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (aw_fire) begin
      ent_id[aw_region]   <= awid;
      ent_addr[aw_region] <= awaddr;
    end
  end

  a_awvalid_onehot: assert property (
    @(posedge aclk) disable iff (!aresetn) $onehot0(awvalid_s)
  );

  a_wvalid_onehot: assert property (
    @(posedge aclk) disable iff (!aresetn) $onehot0(wvalid_s)
  );

  // An open burst must never be overwritten by a new address
  a_no_overwrite: assert property (
    @(posedge aclk) disable iff (!aresetn)
    aw_fire |-> !ent_valid[aw_region]
  );

endmodule

//--- write_path/write_resp_arbiter.sv
`timescale 1ns/1ps

module write_resp_arbiter (
  input  logic [axi_ic_pkg::NUM_SLAVES-1:0]   bvalid_s,
  input  axi_ic_pkg::slv_id_t                 bid_s,
  input  axi_ic_pkg::slv_resp_t               bresp_s,
  input  logic                                bready,
  output logic                                bvalid,
  output axi_ic_pkg::id_t                     bid,
  output axi_ic_pkg::resp_t                   bresp,
  output logic [axi_ic_pkg::NUM_SLAVES-1:0]   bready_s
);

  import axi_ic_pkg::*;

  logic [1:0] sel;

  // Fixed priority, slave 0 first
  always_comb begin
    sel = '0;
    for (int i = NUM_SLAVES - 1; i >= 0; i--) begin
      if (bvalid_s[i]) begin
        sel = 2'(i);
      end
    end
  end

  always_comb begin
    bvalid        = |bvalid_s;
    bid           = bid_s[sel];
    bresp         = bresp_s[sel];
    bready_s      = '0;
    bready_s[sel] = bready && bvalid;
  end

  always_comb begin
    a_bready_onehot: assert ($onehot0(bready_s));
  end

endmodule

//--- read_path/read_router.sv
`timescale 1ns/1ps

module read_router (
  input  logic                                aclk,
  input  logic                                aresetn,
  input  axi_ic_pkg::addr_t                   araddr,
  input  logic                                arvalid,
  input  logic [axi_ic_pkg::NUM_SLAVES-1:0]   arready_s,
  input  logic [axi_ic_pkg::NUM_SLAVES-1:0]   rvalid_s,
  input  axi_ic_pkg::slv_id_t                 rid_s,
  input  axi_ic_pkg::slv_data_t               rdata_s,
  input  axi_ic_pkg::slv_resp_t               rresp_s,
  input  logic [axi_ic_pkg::NUM_SLAVES-1:0]   rlast_s,
  input  logic                                rready,
  output logic                                arready,
  output logic [axi_ic_pkg::NUM_SLAVES-1:0]   arvalid_s,
  output logic                                rvalid,
  output axi_ic_pkg::id_t                     rid,
  output axi_ic_pkg::data_t                   rdata,
  output axi_ic_pkg::resp_t                   rresp,
  output logic                                rlast,
  output logic [axi_ic_pkg::NUM_SLAVES-1:0]   rready_s
);

  import axi_ic_pkg::*;

  region_e    ar_region;
  logic       lock_valid;
  region_e    lock_owner;
  logic [1:0] first_idx;
  region_e    sel;
  logic       sel_valid;
  logic       r_fire;
  logic       r_done;

  assign ar_region = decode_region(araddr);

  always_comb begin
    arvalid_s            = '0;
    arvalid_s[ar_region] = arvalid;
    arready              = arready_s[ar_region];
  end

  // Lowest pending slave when unlocked
  always_comb begin
    first_idx = '0;
    for (int i = NUM_SLAVES - 1; i >= 0; i--) begin
      if (rvalid_s[i]) begin
        first_idx = 2'(i);
      end
    end
  end

  always_comb begin
    if (lock_valid) begin
      sel       = lock_owner; // Hold off the others
      sel_valid = 1'b1;
    end else begin
      sel       = region_e'(first_idx);
      sel_valid = |rvalid_s;
    end
  end

  always_comb begin
    rvalid        = sel_valid && rvalid_s[sel];
    rid           = rid_s[sel];
    rdata         = rdata_s[sel];
    rresp         = rresp_s[sel];
    rlast         = rlast_s[sel];
    rready_s      = '0;
    rready_s[sel] = sel_valid && rready;
  end

  assign r_fire = rvalid && rready;
  assign r_done = r_fire && rlast;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      lock_valid <= 1'b0;
      lock_owner <= REGION_SRAM;
    end else if (r_done) begin
      lock_valid <= 1'b0; // Burst complete, release
    end else if (!lock_valid && sel_valid) begin
      // Grant on sight of rvalid, with or without a transfer
      lock_valid <= 1'b1;
      lock_owner <= sel;
    end
  end

  a_owner_stable: assert property (
    @(posedge aclk) disable iff (!aresetn)
    (lock_valid && !r_done) |=> (lock_valid && (lock_owner == $past(lock_owner)))
  );

  a_rready_onehot: assert property (
    @(posedge aclk) disable iff (!aresetn) $onehot0(rready_s)
  );

endmodule

//--- hdl/axi_ic_top.sv
`timescale 1ns/1ps

module axi_ic_top (
  input  logic                                aclk,
  input  logic                                aresetn,
  // Master side
  input  axi_ic_pkg::addr_t                   awaddr,
  input  axi_ic_pkg::id_t                     awid,
  input  logic                                awvalid,
  output logic                                awready,
  input  axi_ic_pkg::id_t                     wid,
  input  logic                                wlast,
  input  logic                                wvalid,
  output logic                                wready,
  output axi_ic_pkg::id_t                     bid,
  output axi_ic_pkg::resp_t                   bresp,
  output logic                                bvalid,
  input  logic                                bready,
  input  axi_ic_pkg::addr_t                   araddr,
  input  logic                                arvalid,
  output logic                                arready,
  output axi_ic_pkg::data_t                   rdata,
  output axi_ic_pkg::id_t                     rid,
  output axi_ic_pkg::resp_t                   rresp,
  output logic                                rlast,
  output logic                                rvalid,
  input  logic                                rready,
  // Slave side
  output logic [axi_ic_pkg::NUM_SLAVES-1:0]   awvalid_s,
  input  logic [axi_ic_pkg::NUM_SLAVES-1:0]   awready_s,
  output logic [axi_ic_pkg::NUM_SLAVES-1:0]   wvalid_s,
  input  logic [axi_ic_pkg::NUM_SLAVES-1:0]   wready_s,
  input  axi_ic_pkg::slv_id_t                 bid_s,
  input  axi_ic_pkg::slv_resp_t               bresp_s,
  input  logic [axi_ic_pkg::NUM_SLAVES-1:0]   bvalid_s,
  output logic [axi_ic_pkg::NUM_SLAVES-1:0]   bready_s,
  output logic [axi_ic_pkg::NUM_SLAVES-1:0]   arvalid_s,
  input  logic [axi_ic_pkg::NUM_SLAVES-1:0]   arready_s,
  input  axi_ic_pkg::slv_data_t               rdata_s,
  input  axi_ic_pkg::slv_id_t                 rid_s,
  input  axi_ic_pkg::slv_resp_t               rresp_s,
  input  logic [axi_ic_pkg::NUM_SLAVES-1:0]   rlast_s,
  input  logic [axi_ic_pkg::NUM_SLAVES-1:0]   rvalid_s,
  output logic [axi_ic_pkg::NUM_SLAVES-1:0]   rready_s
);

  write_addr_table i_write_addr_table (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .awaddr    (awaddr),
    .awid      (awid),
    .awvalid   (awvalid),
    .awready_s (awready_s),
    .wid       (wid),
    .wvalid    (wvalid),
    .wlast     (wlast),
    .wready_s  (wready_s),
    .awready   (awready),
    .awvalid_s (awvalid_s),
    .wready    (wready),
    .wvalid_s  (wvalid_s)
  );

  write_resp_arbiter i_write_resp_arbiter (
    .bvalid_s (bvalid_s),
    .bid_s    (bid_s),
    .bresp_s  (bresp_s),
    .bready   (bready),
    .bvalid   (bvalid),
    .bid      (bid),
    .bresp    (bresp),
    .bready_s (bready_s)
  );

  read_router i_read_router (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready_s (arready_s),
    .rvalid_s  (rvalid_s),
    .rid_s     (rid_s),
    .rdata_s   (rdata_s),
    .rresp_s   (rresp_s),
    .rlast_s   (rlast_s),
    .rready    (rready),
    .arready   (arready),
    .arvalid_s (arvalid_s),
    .rvalid    (rvalid),
    .rid       (rid),
    .rdata     (rdata),
    .rresp     (rresp),
    .rlast     (rlast),
    .rready_s  (rready_s)
  );

endmodule

//--- testbench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
  input logic aclk, aresetn, awvalid, awready, wlast, wvalid, wready, bvalid, bready,
  input logic arvalid, arready, rlast, rvalid, rready,
  input axi_ic_pkg::addr_t awaddr, araddr,
  input axi_ic_pkg::id_t awid, wid, bid, arid, rid,
  input axi_ic_pkg::resp_t bresp, rresp,
  input axi_ic_pkg::data_t rdata,
  input logic [axi_ic_pkg::NUM_SLAVES-1:0] awvalid_s, awready_s, wvalid_s, wready_s,
  input logic [axi_ic_pkg::NUM_SLAVES-1:0] bvalid_s, bready_s, arvalid_s, arready_s,
  input logic [axi_ic_pkg::NUM_SLAVES-1:0] rvalid_s, rready_s, rlast_s,
  input axi_ic_pkg::slv_id_t bid_s, rid_s,
  input axi_ic_pkg::slv_resp_t bresp_s, rresp_s,
  input axi_ic_pkg::slv_data_t rdata_s,
  output int error_count,
  output int open_items
);

  import axi_ic_pkg::*;

  logic [3:0]  tbl_valid;
  id_t         tbl_id [4];
  logic        lock_v;
  int          lock_o;
  int          beats [4];
  logic        rst_q = 1'b0;
  logic [9:0]  wr_q [$]; // {region, id}
  logic [9:0]  rd_q [$];
  int          aw_total;
  int          ar_total;
  int          b_total;
  int          r_total;

  function automatic int region_of(addr_t a);
    if (a <= SRAM_END) return 0;
    if (a <= ERR1_END) return 1;
    if (a <= APB_END) return 2;
    return 3;
  endfunction

  function automatic int lowest(logic [3:0] v);
    for (int i = 0; i < 4; i++) begin
      if (v[i]) return i;
    end
    return 0;
  endfunction

  task automatic flag(string msg);
    $display("ERROR %0t: %s", $time, msg);
    error_count++;
  endtask

  task automatic expect_eq(string what, logic [127:0] got, logic [127:0] exp);
    if (got !== exp) flag($sformatf("%s is %0h, expected %0h", what, got, exp));
  endtask

  task automatic print_counts();
    $display("Checker: %0d errors, %0d AW, %0d AR, %0d B, %0d R beats, %0d still open",
             error_count, aw_total, ar_total, b_total, r_total, open_items);
  endtask

  always @(posedge aclk) begin : check_cycle
    int         ar, rr, wi, bj, sel, idx;
    logic       whit, selv, aw_fire;
    logic [9:0] key;
    if (!aresetn || !rst_q) begin
      if ((awvalid_s | wvalid_s | arvalid_s) !== 4'b0 || bvalid !== 1'b0 || rvalid !== 1'b0)
        flag("valid output high during or right after reset");
    end
    if (!aresetn) begin
      tbl_valid = '0;
      lock_v    = 1'b0;
      wr_q.delete();
      rd_q.delete();
    end else begin
      ar = region_of(awaddr);
      rr = region_of(araddr);
      expect_eq("awvalid_s", 128'(awvalid_s), 128'((awvalid && !tbl_valid[ar]) ? 4'b1 << ar : 4'b0));
      expect_eq("awready", 128'(awready), 128'(awready_s[ar] && !tbl_valid[ar]));
      expect_eq("arvalid_s", 128'(arvalid_s), 128'(arvalid ? 4'b1 << rr : 4'b0));
      expect_eq("arready", 128'(arready), 128'(arready_s[rr]));
      whit = 1'b0;
      wi   = 0;
      for (int i = 3; i >= 0; i--) begin
        if (tbl_valid[i] && tbl_id[i] == wid) begin
          whit = 1'b1;
          wi   = i;
        end
      end
      expect_eq("wvalid_s", 128'(wvalid_s), 128'((wvalid && whit) ? 4'b1 << wi : 4'b0));
      expect_eq("wready", 128'(wready), 128'(whit && wready_s[wi]));
      bj = lowest(bvalid_s);
      expect_eq("bvalid", 128'(bvalid), 128'(|bvalid_s));
      if (bvalid_s != 4'b0) begin
        expect_eq("bid", 128'(bid), 128'(bid_s[bj]));
        expect_eq("bresp", 128'(bresp), 128'(bresp_s[bj]));
      end
      expect_eq("bready_s", 128'(bready_s), 128'((bready && |bvalid_s) ? 4'b1 << bj : 4'b0));
      sel  = lock_v ? lock_o : lowest(rvalid_s); // Lock model
      selv = lock_v || (|rvalid_s);
      expect_eq("rvalid", 128'(rvalid), 128'(selv && rvalid_s[sel]));
      if (selv && rvalid_s[sel]) begin
        expect_eq("rid", 128'(rid), 128'(rid_s[sel]));
        expect_eq("rdata", rdata, rdata_s[sel]);
        expect_eq("rresp", 128'(rresp), 128'(rresp_s[sel]));
        expect_eq("rlast", 128'(rlast), 128'(rlast_s[sel]));
      end
      expect_eq("rready_s", 128'(rready_s), 128'((selv && rready) ? 4'b1 << sel : 4'b0));
      aw_fire = awvalid && awready;
      if (aw_fire) begin
        if (tbl_valid[ar]) flag("AW accepted to a region whose write burst is still open");
        aw_total++;
        wr_q.push_back({2'(ar), awid});
      end
      if (wvalid && wready && wlast) tbl_valid[wi] = 1'b0;
      if (aw_fire) begin
        tbl_valid[ar] = 1'b1;
        tbl_id[ar]    = awid;
      end
      if (arvalid && arready) begin
        ar_total++;
        rd_q.push_back({2'(rr), arid});
      end
      if (bvalid && bready) begin
        b_total++;
        key = {2'(bj), bid};
        idx = -1;
        foreach (wr_q[i]) if (idx < 0 && wr_q[i] == key) idx = i;
        if (idx < 0) flag($sformatf("B with id %0h from slave %0d matches no write", bid, bj));
        else wr_q.delete(idx);
        expect_eq("bresp slave", 128'(bresp), 128'(bj));
      end
      if (rvalid && rready) begin
        r_total++;
        expect_eq("rdata pattern", rdata, {4{8'(sel), rid, 8'(beats[sel]), 8'hc3}});
        expect_eq("rresp slave", 128'(rresp), 128'(sel));
        expect_eq("rlast position", 128'(rlast), 128'(beats[sel] == int'(rid[1:0])));
        if (rlast) begin
          key = {2'(sel), rid};
          idx = -1;
          foreach (rd_q[i]) if (idx < 0 && rd_q[i] == key) idx = i;
          if (idx < 0) flag($sformatf("R burst id %0h from slave %0d matches no read", rid, sel));
          else rd_q.delete(idx);
          beats[sel] = 0;
        end else begin
          beats[sel]++;
        end
      end
      if (rvalid && rready && rlast) begin
        lock_v = 1'b0;
      end else if (!lock_v && (|rvalid_s)) begin
        lock_v = 1'b1;
        lock_o = sel;
      end
    end
    rst_q      = aresetn;
    open_items = wr_q.size() + rd_q.size();
  end

endmodule

//--- testbench/tb_axi_ic.sv
`timescale 1ns/1ps

module slave_stub #(
  parameter int IDX = 0
) (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic [7:0]            rnd,
  input  logic                  awvalid,
  input  axi_ic_pkg::id_t       awid,
  input  logic                  wvalid,
  input  logic                  wlast,
  input  logic                  bready,
  input  logic                  arvalid,
  input  axi_ic_pkg::id_t       arid,
  input  logic                  rready,
  output logic                  awready = 1'b0,
  output logic                  wready = 1'b0,
  output logic                  arready = 1'b0,
  output logic                  bvalid = 1'b0,
  output axi_ic_pkg::id_t       bid = '0,
  output axi_ic_pkg::resp_t     bresp = '0,
  output logic                  rvalid = 1'b0,
  output axi_ic_pkg::id_t       rid = '0,
  output axi_ic_pkg::data_t     rdata = '0,
  output axi_ic_pkg::resp_t     rresp = '0,
  output logic                  rlast = 1'b0
);

  import axi_ic_pkg::*;

  id_t q_b [$];
  id_t q_r [$];
  id_t cur_id;
  int  beat;
  int  b_cnt;
  int  b_seen;
  int  r_cnt;
  int  r_seen;

  // Handshakes seen on the rising edge
  always @(posedge aclk) begin
    if (awvalid && awready) cur_id = awid;
    if (wvalid && wready && wlast) q_b.push_back(cur_id);
    if (bvalid && bready) begin
      void'(q_b.pop_front());
      b_cnt++;
    end
    if (arvalid && arready) q_r.push_back(arid);
    if (rvalid && rready) begin
      r_cnt++;
      if (rlast) begin
        void'(q_r.pop_front());
        beat = 0;
      end else begin
        beat++;
      end
    end
  end

  always @(negedge aclk) begin
    if (!aresetn) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      arready <= 1'b0;
      bvalid  <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      awready <= rnd[0];
      wready  <= rnd[1];
      arready <= rnd[2];
      if (b_cnt != b_seen) begin
        b_seen = b_cnt;
        bvalid <= 1'b0;
      end else if (!bvalid && q_b.size() != 0 && rnd[3]) begin
        bvalid <= 1'b1;
        bid    <= q_b[0];
        bresp  <= resp_t'(IDX); // Response names the slave
      end
      if (r_cnt != r_seen) begin
        r_seen = r_cnt;
        rvalid <= 1'b0;
      end else if (!rvalid && q_r.size() != 0 && rnd[4]) begin
        rvalid <= 1'b1;
        rid    <= q_r[0];
        rdata  <= {4{8'(IDX), q_r[0], 8'(beat), 8'hc3}};
        rresp  <= resp_t'(IDX);
        rlast  <= (beat == int'(q_r[0][1:0])); // ID low bits hold length minus one
      end
    end
  end

endmodule

module tb_axi_ic;

  import axi_ic_pkg::*;

  localparam int PERIOD     = 40;
  localparam int NUM_WRITES = 200;
  localparam int NUM_READS  = 200;
  localparam int TIMEOUT_NS = (NUM_WRITES + NUM_READS) * 64 * PERIOD;

  logic aclk = 1'b0;
  logic aresetn;
  addr_t awaddr;
  id_t awid;
  logic awvalid;
  logic awready;
  id_t wid;
  logic wlast;
  logic wvalid;
  logic wready;
  id_t bid;
  resp_t bresp;
  logic bvalid;
  logic bready = 1'b0;
  addr_t araddr;
  id_t arid;
  logic arvalid;
  logic arready;
  data_t rdata;
  id_t rid;
  resp_t rresp;
  logic rlast;
  logic rvalid;
  logic rready = 1'b0;
  logic [NUM_SLAVES-1:0] awvalid_s, awready_s, wvalid_s, wready_s, bvalid_s, bready_s;
  logic [NUM_SLAVES-1:0] arvalid_s, arready_s, rlast_s, rvalid_s, rready_s;
  slv_id_t bid_s;
  slv_id_t rid_s;
  slv_resp_t bresp_s;
  slv_resp_t rresp_s;
  slv_data_t rdata_s;
  int error_count;
  int open_items;
  id_t w_pending [$]; // Accepted AW IDs awaiting W

  logic [31:0]  lfsr = 32'h9548;
  logic [127:0] rnd_pool = '0;

  always #(PERIOD / 2) aclk = ~aclk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  always @(posedge aclk) begin
    rnd_pool[31:0]   <= take_bits(32);
    rnd_pool[63:32]  <= take_bits(32);
    rnd_pool[95:64]  <= take_bits(32);
    rnd_pool[127:96] <= take_bits(32);
  end

  function automatic addr_t pick_addr(logic [31:0] r);
    case (r[1:0])
      2'd0:    return SRAM_START + addr_t'(r[26:2]);
      2'd1:    return ERR1_START + addr_t'(r[28:2]);
      2'd2:    return APB_START + addr_t'(r[29:2]);
      default: return ERR2_START + addr_t'({r[31:2], 6'h0});
    endcase
  endfunction

  // Low two bits give the burst length minus one
  function automatic id_t pick_id(logic [31:0] r);
    logic [1:0] code;
    code = (r[17:16] == 2'd3) ? 2'd0 : r[17:16];
    return {r[15:10], code};
  endfunction

  axi_ic_top i_dut (.*);

  tb_checker i_checker (.*);

  for (genvar g = 0; g < NUM_SLAVES; g++) begin : g_slave
    slave_stub #(.IDX(g)) i_slave (
      .aclk    (aclk),
      .aresetn (aresetn),
      .rnd     (rnd_pool[72+8*g +: 8]),
      .awvalid (awvalid_s[g]),
      .awid    (awid),
      .wvalid  (wvalid_s[g]),
      .wlast   (wlast),
      .bready  (bready_s[g]),
      .arvalid (arvalid_s[g]),
      .arid    (arid),
      .rready  (rready_s[g]),
      .awready (awready_s[g]),
      .wready  (wready_s[g]),
      .arready (arready_s[g]),
      .bvalid  (bvalid_s[g]),
      .bid     (bid_s[g]),
      .bresp   (bresp_s[g]),
      .rvalid  (rvalid_s[g]),
      .rid     (rid_s[g]),
      .rdata   (rdata_s[g]),
      .rresp   (rresp_s[g]),
      .rlast   (rlast_s[g])
    );
  end

  always @(negedge aclk) begin
    bready <= aresetn && rnd_pool[64];
    rready <= aresetn && rnd_pool[65];
  end

  // Next AW overlaps the open W burst
  task automatic write_addr_all();
    for (int n = 0; n < NUM_WRITES; n++) begin
      while (w_pending.size() >= 2) @(negedge aclk);
      awaddr  = pick_addr(rnd_pool[31:0]);
      awid    = pick_id(rnd_pool[31:0]);
      awid[2] = n[0]; // Open entries never share an ID
      awvalid = 1'b1;
      do @(posedge aclk); while (!awready);
      w_pending.push_back(awid);
      @(negedge aclk);
      awvalid = 1'b0;
    end
  endtask

  task automatic write_data_all();
    id_t id;
    int  len;
    for (int n = 0; n < NUM_WRITES; n++) begin
      while (w_pending.size() == 0) @(negedge aclk);
      id  = w_pending[0];
      len = int'(id[1:0]) + 1;
      for (int b = 0; b < len; b++) begin
        wid    = id;
        wlast  = (b == len - 1);
        wvalid = 1'b1;
        do @(posedge aclk); while (!wready);
        if (wlast) begin
          void'(w_pending.pop_front());
        end
        @(negedge aclk);
      end
      wvalid = 1'b0;
      wlast  = 1'b0;
    end
  endtask

  task automatic read_all();
    for (int n = 0; n < NUM_READS; n++) begin
      araddr  = pick_addr(rnd_pool[63:32]);
      arid    = pick_id(rnd_pool[63:32]);
      arvalid = 1'b1;
      do @(posedge aclk); while (!arready);
      @(negedge aclk);
      arvalid = 1'b0;
    end
  endtask

  initial begin
    aresetn = 1'b0;
    awaddr  = '0;
    awid    = '0;
    awvalid = 1'b0;
    wid     = '0;
    wlast   = 1'b0;
    wvalid  = 1'b0;
    araddr  = '0;
    arid    = '0;
    arvalid = 1'b0;
    repeat (4) @(negedge aclk);
    aresetn = 1'b1;
    @(negedge aclk);
    fork
      write_addr_all();
      write_data_all();
      read_all();
    join
    while (open_items != 0) @(posedge aclk); // Drain B and R
    repeat (2) @(posedge aclk);
    i_checker.print_counts();
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the transactions did not complete within the time limit");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- build.f
common/axi_ic_pkg.sv
write_path/write_addr_table.sv
write_path/write_resp_arbiter.sv
read_path/read_router.sv
hdl/axi_ic_top.sv
testbench/tb_checker.sv
testbench/tb_axi_ic.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module tb_axi_ic -o tb_axi_ic
out=$(./obj_dir/tb_axi_ic)
echo "$out"
if echo "$out" | grep -qx "NO ERRORS"; then
  exit 0
else
  exit 1
fi
